/* exu_top.f */
+incdir+hdl
hdl/exu_csr_pkg.sv
hdl/exu_op_pkg.sv
hdl/lsu_if.sv
hdl/exu_alu.sv
hdl/exu_csr_file.sv
hdl/exu_core.sv
hdl/exu_data_ram.sv
hdl/exu_top.sv
verif/exu_top_assert.sv
verif/exu_top_tb.sv

/* verif/exu_top_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module exu_top_tb;

  import exu_op_pkg::*;
  import exu_csr_pkg::*;

  localparam int XL = `EXU_XLEN;

  logic          clk;
  logic          rst;
  logic          in_valid_i;
  logic          in_ready_o;
  opcode_e       in_opcode_i;
  alu_op_e       in_alu_op_i;
  sys_func_e     in_sys_func_i;
  logic [11:0]   in_csr_i;
  logic [4:0]    in_rd_i;
  logic          in_rf_we_i;
  logic [XL-1:0] in_src1_i;
  logic [XL-1:0] in_src2_i;
  logic [XL-1:0] in_base_i;
  logic [XL-1:0] in_imm_i;
  logic [XL-1:0] in_pc_i;
  logic          out_valid_o;
  logic          out_ready_i;
  logic [4:0]    out_rd_o;
  logic          out_rf_we_o;
  logic [XL-1:0] out_rf_wdata_o;
  logic          out_redirect_o;
  logic [XL-1:0] out_npc_o;
  logic          out_ebreak_o;

  // reference model state
  logic [XL-1:0] shadow_mem [`EXU_DMEM_WORDS];
  logic [XL-1:0] sh_mstatus;
  logic [XL-1:0] sh_mtvec;
  logic [XL-1:0] sh_mepc;
  logic [XL-1:0] sh_mcause;

  issue_t        ins;
  logic [XL-1:0] rng_state;
  bit            backpressure;
  int            test_errs;
  int            total_errs;
  int            tests_run;
  int            tests_failed;
  int            assert_seen;

  // last result taken from the DUT
  logic [4:0]    res_rd;
  logic          res_rf_we;
  logic [XL-1:0] res_wdata;
  logic          res_redirect;
  logic [XL-1:0] res_npc;
  logic          res_ebreak;

  exu_top UUT (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  function automatic logic [XL-1:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 7);
    rng_state = rng_state ^ (rng_state << 17);
    return rng_state;
  endfunction

  function automatic logic [XL-1:0] alu_model(alu_op_e op, logic [XL-1:0] a, logic [XL-1:0] b);
    logic signed [XL-1:0] sa;
    logic signed [XL-1:0] sb;
    int unsigned          sh;
    sa = a;
    sb = b;
    sh = b % XL;
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_SLL:  return a << sh;
      ALU_SLT:  return (sa < sb) ? 1 : 0;
      ALU_SLTU: return (a < b) ? 1 : 0;
      ALU_XOR:  return a ^ b;
      ALU_SRL:  return a >> sh;
      ALU_SRA:  return sa >>> sh;
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      ALU_SLE:  return (sa > sb) ? 0 : 1;
      ALU_SLEU: return (a > b) ? 0 : 1;
      default:  return '0;
    endcase
  endfunction

  function automatic logic [XL-1:0] read_shadow_csr(logic [11:0] addr);
    case (addr)
      CSR_MSTATUS: return sh_mstatus;
      CSR_MTVEC:   return sh_mtvec;
      CSR_MEPC:    return sh_mepc;
      CSR_MCAUSE:  return sh_mcause;
      default:     return '0;
    endcase
  endfunction

  task automatic write_shadow_csr(input logic [11:0] addr, input logic [XL-1:0] val);
    case (addr)
      CSR_MSTATUS: sh_mstatus = val;
      CSR_MTVEC:   sh_mtvec = val;
      CSR_MEPC:    sh_mepc = val;
      CSR_MCAUSE:  sh_mcause = val;
      default:     ;
    endcase
  endtask

  task automatic check(input string name, input logic [XL-1:0] got, input logic [XL-1:0] exp);
    assert (got === exp) else begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic drive_issue();
    in_opcode_i   = ins.opcode;
    in_alu_op_i   = ins.alu_op;
    in_sys_func_i = ins.sys_func;
    in_csr_i      = ins.csr;
    in_rd_i       = ins.rd;
    in_rf_we_i    = ins.rf_we;
    in_src1_i     = ins.src1;
    in_src2_i     = ins.src2;
    in_base_i     = ins.base;
    in_imm_i      = ins.imm;
    in_pc_i       = ins.pc;
  endtask

  task automatic send();
    int waited;
    waited = 0;
    @(negedge clk);
    // the previous result must not come back a second time
    check("out_valid_o", out_valid_o, 1'b0);
    drive_issue();
    in_valid_i = 1'b1;
    while (!in_ready_o && waited < 50) begin
      @(negedge clk);
      waited++;
    end
    if (!in_ready_o) begin
      $display("timeout: the DUT did not accept an instruction within 50 cycles");
      $display("sim failed");
      $finish;
    end
    @(posedge clk);
    @(negedge clk);
    in_valid_i = 1'b0;
  endtask

  task automatic get_result();
    int            waited;
    bit            taken;
    logic [XL-1:0] r;
    waited = 0;
    taken  = 1'b0;
    while (!taken && waited <= 50) begin
      @(negedge clk);
      r = next_rand();
      out_ready_i = backpressure ? r[0] : 1'b1;
      // a busy DUT must not take the instruction again
      in_valid_i = !out_valid_o;
      if (out_valid_o && out_ready_i) begin
        res_rd       = out_rd_o;
        res_rf_we    = out_rf_we_o;
        res_wdata    = out_rf_wdata_o;
        res_redirect = out_redirect_o;
        res_npc      = out_npc_o;
        res_ebreak   = out_ebreak_o;
        taken        = 1'b1;
      end else begin
        waited++;
      end
    end
    if (!taken) begin
      $display("timeout: no result from the DUT within 50 cycles");
      $display("sim failed");
      $finish;
    end
    @(posedge clk);
  endtask

  task automatic alu_batch(input int n);
    logic [XL-1:0] r;
    for (int i = 0; i < n; i++) begin
      r = next_rand();
      ins = '0;
      ins.opcode = OP_ALU_REG;
      ins.alu_op = alu_op_e'(r % 12);
      ins.rd     = r[20:16];
      ins.rf_we  = 1'b1;
      ins.src1   = next_rand();
      ins.src2   = next_rand();
      ins.pc     = r & ~64'd3;
      send();
      get_result();
      check("out_rf_wdata_o", res_wdata, alu_model(ins.alu_op, ins.src1, ins.src2));
      check("out_rd_o", res_rd, ins.rd);
      check("out_rf_we_o", res_rf_we, 1'b1);
      check("out_redirect_o", res_redirect, 1'b0);
    end
  endtask

  task automatic branches_and_jumps(input int n);
    logic [XL-1:0] a;
    logic [XL-1:0] b;
    logic [XL-1:0] r;
    bit            taken;
    for (int i = 0; i < n; i++) begin
      a = next_rand();
      r = next_rand();
      b = r[0] ? a : next_rand();
      ins = '0;
      ins.opcode = OP_BRANCH;
      ins.pc     = r & ~64'd3;
      ins.base   = ins.pc;
      ins.imm    = {{51{r[12]}}, r[12:1], 1'b0};
      ins.src1   = a;
      ins.src2   = b;
      case (i % 6)
        0: begin
          ins.alu_op = ALU_SUB;
          taken = a == b;
        end
        1: begin
          ins.alu_op = ALU_XOR;
          taken = a != b;
        end
        2: begin
          ins.alu_op = ALU_SLT;
          taken = $signed(a) < $signed(b);
        end
        3: begin
          ins.alu_op = ALU_SLTU;
          taken = a < b;
        end
        // bge and bgeu swap the operands
        4: begin
          ins.alu_op = ALU_SLE;
          ins.src1   = b;
          ins.src2   = a;
          taken = $signed(a) >= $signed(b);
        end
        default: begin
          ins.alu_op = ALU_SLEU;
          ins.src1   = b;
          ins.src2   = a;
          taken = a >= b;
        end
      endcase
      send();
      get_result();
      check("out_redirect_o", res_redirect, taken);
      if (taken) begin
        check("out_npc_o", res_npc, ins.pc + ins.imm);
      end
    end
    for (int j = 0; j < 2; j++) begin
      r = next_rand();
      ins = '0;
      ins.opcode = (j == 0) ? OP_JAL : OP_JALR;
      ins.pc     = r & ~64'd3;
      ins.base   = (j == 0) ? ins.pc : (next_rand() & ~64'd1);
      ins.imm    = {{51{r[12]}}, r[12:1], 1'b0};
      // link value comes out of the adder
      ins.src1   = ins.pc;
      ins.src2   = 64'd4;
      ins.rd     = 5'd1;
      ins.rf_we  = 1'b1;
      send();
      get_result();
      check("out_redirect_o", res_redirect, 1'b1);
      check("out_npc_o", res_npc, ins.base + ins.imm);
      check("out_rf_wdata_o", res_wdata, ins.pc + 64'd4);
    end
  endtask

  task automatic mem_access(input bit write, input int idx, input logic [XL-1:0] data);
    logic [XL-1:0] addr;
    addr = XL'(idx) * 8;
    ins = '0;
    ins.opcode = write ? OP_STORE : OP_LOAD;
    ins.base   = next_rand() & ~64'd7;
    ins.imm    = addr - ins.base;
    ins.src2   = data;
    ins.rd     = write ? 5'd0 : 5'd9;
    ins.rf_we  = !write;
    send();
    get_result();
    check("out_redirect_o", res_redirect, 1'b0);
    check("out_rf_we_o", res_rf_we, !write);
    if (write) begin
      shadow_mem[idx] = data;
    end else begin
      check("out_rf_wdata_o", res_wdata, shadow_mem[idx]);
      check("out_rd_o", res_rd, 5'd9);
    end
  endtask

  task automatic store_load_batch(input int n);
    int idx_q[$];
    int idx;
    // top word has not been stored to yet in the first pass
    mem_access(1'b0, `EXU_DMEM_WORDS - 1, '0);
    for (int i = 0; i < n; i++) begin
      idx = int'(next_rand() % `EXU_DMEM_WORDS);
      idx_q.push_back(idx);
      mem_access(1'b1, idx, next_rand());
    end
    foreach (idx_q[k]) begin
      mem_access(1'b0, idx_q[k], '0);
    end
  endtask

  task automatic csr_op(input sys_func_e func, input logic [11:0] addr, input logic [XL-1:0] val);
    logic [XL-1:0] old;
    old = read_shadow_csr(addr);
    ins = '0;
    ins.opcode   = OP_SYSTEM;
    ins.sys_func = func;
    ins.csr      = addr;
    ins.rd       = 5'd7;
    ins.rf_we    = 1'b1;
    ins.src1     = val;
    send();
    get_result();
    check("out_rf_wdata_o", res_wdata, old);
    check("out_redirect_o", res_redirect, 1'b0);
    case (func)
      SYS_CSRRS, SYS_CSRRSI: write_shadow_csr(addr, old | val);
      SYS_CSRRC, SYS_CSRRCI: write_shadow_csr(addr, old & ~val);
      default:               write_shadow_csr(addr, val);
    endcase
  endtask

  task automatic csr_walk();
    logic [11:0] addr;
    for (int k = 0; k < 2; k++) begin
      addr = (k == 0) ? CSR_MTVEC : CSR_MEPC;
      csr_op(SYS_CSRRW, addr, next_rand());
      csr_op(SYS_CSRRS, addr, '0);
      csr_op(SYS_CSRRS, addr, next_rand());
      csr_op(SYS_CSRRS, addr, '0);
      csr_op(SYS_CSRRC, addr, next_rand());
      csr_op(SYS_CSRRS, addr, '0);
      csr_op(SYS_CSRRWI, addr, 64'd21);
      csr_op(SYS_CSRRSI, addr, 64'd10);
      csr_op(SYS_CSRRCI, addr, 64'd3);
      csr_op(SYS_CSRRS, addr, '0);
    end
  endtask

  task automatic priv_op(input priv_code_e code, input logic [XL-1:0] pc);
    ins = '0;
    ins.opcode   = OP_SYSTEM;
    ins.sys_func = SYS_PRIV;
    ins.csr      = code;
    ins.pc       = pc;
    send();
    get_result();
  endtask

  task automatic trap_checks();
    logic [XL-1:0] pc;
    pc = next_rand() & ~64'd3;
    priv_op(PRIV_ECALL, pc);
    check("out_redirect_o", res_redirect, 1'b1);
    check("out_npc_o", res_npc, sh_mtvec);
    sh_mepc   = pc;
    sh_mcause = CAUSE_ECALL_M;
    csr_op(SYS_CSRRS, CSR_MEPC, '0);
    csr_op(SYS_CSRRS, CSR_MCAUSE, '0);
    // MIE set and MPIE clear going into mret
    csr_op(SYS_CSRRW, CSR_MSTATUS, 64'd1 << MSTATUS_MIE);
    priv_op(PRIV_MRET, pc + 64'd4);
    check("out_redirect_o", res_redirect, 1'b1);
    check("out_npc_o", res_npc, sh_mepc);
    sh_mstatus[MSTATUS_MIE]  = sh_mstatus[MSTATUS_MPIE];
    sh_mstatus[MSTATUS_MPIE] = 1'b1;
    csr_op(SYS_CSRRS, CSR_MSTATUS, '0);
    priv_op(PRIV_EBREAK, pc + 64'd8);
    check("out_ebreak_o", res_ebreak, 1'b1);
    check("out_redirect_o", res_redirect, 1'b0);
  endtask

  task automatic report_test(input string name);
    int errs;
    errs = test_errs + UUT.u_core.u_assert.fails - assert_seen;
    assert_seen = UUT.u_core.u_assert.fails;
    if (errs == 0) begin
      $display("test %-16s ok", name);
    end else begin
      $display("test %-16s FAILED with %0d errors", name, errs);
      tests_failed++;
    end
    total_errs += errs;
    tests_run++;
    test_errs = 0;
  endtask

  initial begin
    rng_state    = 64'd84;
    rst          = 1'b1;
    in_valid_i   = 1'b0;
    out_ready_i  = 1'b0;
    backpressure = 1'b0;
    ins          = '0;
    drive_issue();
    foreach (shadow_mem[i]) begin
      shadow_mem[i] = '0;
    end
    sh_mstatus   = '0;
    sh_mtvec     = `EXU_MTVEC_RESET;
    sh_mepc      = '0;
    sh_mcause    = '0;
    test_errs    = 0;
    total_errs   = 0;
    tests_run    = 0;
    tests_failed = 0;
    assert_seen  = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    alu_batch(40);
    report_test("alu");
    branches_and_jumps(24);
    report_test("branch_jump");
    store_load_batch(12);
    report_test("memory");
    csr_walk();
    report_test("csr");
    trap_checks();
    report_test("trap");

    // random consumer stalls, then reads show no repeated writes
    backpressure = 1'b1;
    alu_batch(40);
    store_load_batch(12);
    csr_op(SYS_CSRRS, CSR_MTVEC, '0);
    csr_op(SYS_CSRRS, CSR_MEPC, '0);
    csr_op(SYS_CSRRS, CSR_MSTATUS, '0);
    report_test("backpressure");

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
    if (total_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/exu_top_assert.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module exu_top_assert (
  input wire                 clk,
  input wire                 rst,
  input wire                 issue_valid_i,
  input wire                 issue_ready_i,
  input wire                 res_valid_i,
  input wire                 res_ready_i,
  input wire [4:0]           res_rd_i,
  input wire                 res_rf_we_i,
  input wire [`EXU_XLEN-1:0] res_wdata_i,
  input wire                 res_redirect_i,
  input wire [`EXU_XLEN-1:0] res_npc_i,
  input wire                 res_ebreak_i,
  input wire                 req_valid_i,
  input wire                 rsp_valid_i
);

  int fails = 0;

  logic [2*`EXU_XLEN+7:0] res_fields;

  assign res_fields = {res_rd_i, res_rf_we_i, res_wdata_i, res_redirect_i, res_npc_i,
                       res_ebreak_i};

  // a held result keeps every field
  result_stable: assert property (@(posedge clk) disable iff (rst)
    res_valid_i && !res_ready_i |=> res_valid_i && $stable(res_fields))
    else begin
      $error("result changed while held by the consumer");
      fails++;
    end

  req_held: assert property (@(posedge clk) disable iff (rst)
    req_valid_i && !rsp_valid_i |=> req_valid_i)
    else begin
      $error("memory request dropped before its response");
      fails++;
    end

  no_issue_in_mem: assert property (@(posedge clk) disable iff (rst)
    req_valid_i |-> !(issue_valid_i && issue_ready_i))
    else begin
      $error("instruction accepted while a memory access was open");
      fails++;
    end

  reset_state: assert property (@(posedge clk)
    rst |=> !res_valid_i && !req_valid_i && !res_redirect_i && !res_ebreak_i && issue_ready_i)
    else begin
      $error("outputs not in their idle state after reset");
      fails++;
    end

endmodule

bind exu_core exu_top_assert u_assert (
  .clk            (clk),
  .rst            (rst),
  .issue_valid_i  (issue_valid_i),
  .issue_ready_i  (issue_ready_o),
  .res_valid_i    (res_valid_o),
  .res_ready_i    (res_ready_i),
  .res_rd_i       (res_rd_o),
  .res_rf_we_i    (res_rf_we_o),
  .res_wdata_i    (res_wdata_o),
  .res_redirect_i (res_redirect_o),
  .res_npc_i      (res_npc_o),
  .res_ebreak_i   (res_ebreak_o),
  .req_valid_i    (lsu.req_valid),
  .rsp_valid_i    (lsu.rsp_valid)
);

`default_nettype wire

/* hdl/exu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module exu_top (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        in_valid_i,
  output logic                       in_ready_o,
  input  wire exu_op_pkg::opcode_e   in_opcode_i,
  input  wire exu_op_pkg::alu_op_e   in_alu_op_i,
  input  wire exu_csr_pkg::sys_func_e in_sys_func_i,
  input  wire [11:0]                 in_csr_i,
  input  wire [4:0]                  in_rd_i,
  input  wire                        in_rf_we_i,
  input  wire [`EXU_XLEN-1:0]        in_src1_i,
  input  wire [`EXU_XLEN-1:0]        in_src2_i,
  input  wire [`EXU_XLEN-1:0]        in_base_i,
  input  wire [`EXU_XLEN-1:0]        in_imm_i,
  input  wire [`EXU_XLEN-1:0]        in_pc_i,
  output logic                       out_valid_o,
  input  wire                        out_ready_i,
  output logic [4:0]                 out_rd_o,
  output logic                       out_rf_we_o,
  output logic [`EXU_XLEN-1:0]       out_rf_wdata_o,
  output logic                       out_redirect_o,
  output logic [`EXU_XLEN-1:0]       out_npc_o,
  output logic                       out_ebreak_o
);

  import exu_op_pkg::*;

  issue_t issue;

  lsu_if lsu_bus ();

  assign issue = '{
    opcode:   in_opcode_i,
    alu_op:   in_alu_op_i,
    sys_func: in_sys_func_i,
    csr:      in_csr_i,
    rd:       in_rd_i,
    rf_we:    in_rf_we_i,
    src1:     in_src1_i,
    src2:     in_src2_i,
    base:     in_base_i,
    imm:      in_imm_i,
    pc:       in_pc_i
  };

  exu_core u_core (
    .clk            (clk),
    .rst            (rst),
    .issue_valid_i  (in_valid_i),
    .issue_ready_o  (in_ready_o),
    .issue_i        (issue),
    .res_valid_o    (out_valid_o),
    .res_ready_i    (out_ready_i),
    .res_rd_o       (out_rd_o),
    .res_rf_we_o    (out_rf_we_o),
    .res_wdata_o    (out_rf_wdata_o),
    .res_redirect_o (out_redirect_o),
    .res_npc_o      (out_npc_o),
    .res_ebreak_o   (out_ebreak_o),
    .lsu            (lsu_bus.core)
  );

  exu_data_ram u_ram (
    .clk (clk),
    .rst (rst),
    .bus (lsu_bus.mem)
  );

endmodule

`default_nettype wire

/* hdl/exu_data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module exu_data_ram (
  input wire  clk,
  input wire  rst,
  lsu_if.mem  bus
);

  localparam int IDX_W = $clog2(`EXU_DMEM_WORDS);

  logic [`EXU_XLEN-1:0]       mem [`EXU_DMEM_WORDS];
  // per-word flag so untouched words read as zero
  logic [`EXU_DMEM_WORDS-1:0] written;
  logic                       busy;
  logic                       rsp_valid_q;
  logic [`EXU_XLEN-1:0]       rdata_q;
  logic [IDX_W-1:0]           idx;
  logic                       serve;

  // doubleword index, byte offset dropped
  assign idx   = bus.req_addr[IDX_W+2:3];
  assign serve = bus.req_valid && !busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy        <= 1'b0;
      rsp_valid_q <= 1'b0;
      written     <= '0;
    end else begin
      rsp_valid_q <= serve;
      if (serve) begin
        busy <= 1'b1;
      end else if (!bus.req_valid) begin
        busy <= 1'b0;
      end
      if (serve && bus.req_write) begin
        written[idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (serve) begin
      if (bus.req_write) begin
        mem[idx] <= bus.req_wdata;
      end else begin
        rdata_q <= written[idx] ? mem[idx] : '0;
      end
    end
  end

  assign bus.rsp_valid = rsp_valid_q;
  assign bus.rsp_rdata = rdata_q;

endmodule

`default_nettype wire

/* hdl/exu_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module exu_core (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  issue_valid_i,
  output logic                 issue_ready_o,
  input  wire exu_op_pkg::issue_t issue_i,
  output logic                 res_valid_o,
  input  wire                  res_ready_i,
  output logic [4:0]           res_rd_o,
  output logic                 res_rf_we_o,
  output logic [`EXU_XLEN-1:0] res_wdata_o,
  output logic                 res_redirect_o,
  output logic [`EXU_XLEN-1:0] res_npc_o,
  output logic                 res_ebreak_o,
  lsu_if.core                  lsu
);

  import exu_op_pkg::*;
  import exu_csr_pkg::*;

  issue_t               issue_q;
  logic                 busy;
  logic                 req_q;
  logic                 res_valid_q;
  logic                 redirect_q;
  logic                 ebreak_q;
  logic [`EXU_XLEN-1:0] wdata_q;
  logic [`EXU_XLEN-1:0] npc_q;

  logic                 accept;
  logic                 is_mem;
  logic                 is_sys;
  logic                 exec_fire;
  logic                 mem_done;
  logic [`EXU_XLEN-1:0] jump_target;
  logic [`EXU_XLEN-1:0] alu_res;
  logic [`EXU_XLEN-1:0] csr_rdata;
  logic [`EXU_XLEN-1:0] csr_wdata;
  logic [`EXU_XLEN-1:0] mtvec;
  logic [`EXU_XLEN-1:0] mepc;
  logic [`EXU_XLEN-1:0] wb_data;
  logic [`EXU_XLEN-1:0] npc;
  logic                 redirect;
  logic                 ebreak;
  logic                 trap;
  logic                 mret;

  // one instruction in flight, captured until its result is produced
  assign issue_ready_o = !busy && (!res_valid_q || res_ready_i);
  assign accept        = issue_valid_i && issue_ready_o;
  assign is_mem        = issue_q.opcode inside {OP_LOAD, OP_STORE};
  assign is_sys        = issue_q.opcode == OP_SYSTEM;
  assign exec_fire     = busy && !is_mem;
  assign mem_done      = busy && is_mem && lsu.rsp_valid;
  assign jump_target   = issue_q.base + issue_q.imm;

  exu_alu u_alu (
    .src1_i (issue_q.src1),
    .src2_i (issue_q.src2),
    .op_i   (issue_q.alu_op),
    .res_o  (alu_res)
  );

  exu_csr_file u_csr (
    .clk       (clk),
    .rst       (rst),
    .raddr_i   (issue_q.csr),
    .rdata_o   (csr_rdata),
    .we_i      (exec_fire && is_sys && issue_q.sys_func != SYS_PRIV),
    .waddr_i   (issue_q.csr),
    .wdata_i   (csr_wdata),
    .trap_i    (exec_fire && trap),
    .trap_pc_i (issue_q.pc),
    .mret_i    (exec_fire && mret),
    .mtvec_o   (mtvec),
    .mepc_o    (mepc)
  );

  // immediate forms arrive with the zero-extended uimm in src1
  always_comb begin
    case (issue_q.sys_func)
      SYS_CSRRS, SYS_CSRRSI: csr_wdata = csr_rdata | issue_q.src1;
      SYS_CSRRC, SYS_CSRRCI: csr_wdata = csr_rdata & ~issue_q.src1;
      default:               csr_wdata = issue_q.src1;
    endcase
  end

  always_comb begin
    redirect = 1'b0;
    ebreak   = 1'b0;
    trap     = 1'b0;
    mret     = 1'b0;
    npc      = jump_target;
    case (issue_q.opcode)
      OP_JAL, OP_JALR: redirect = 1'b1;
      // beq is a sub, the other compares are taken on nonzero
      OP_BRANCH: redirect = (issue_q.alu_op == ALU_SUB) ? ~|alu_res : |alu_res;
      OP_SYSTEM: begin
        if (issue_q.sys_func == SYS_PRIV) begin
          if (issue_q.csr == PRIV_ECALL) begin
            trap     = 1'b1;
            redirect = 1'b1;
            npc      = mtvec;
          end else if (issue_q.csr == PRIV_MRET) begin
            mret     = 1'b1;
            redirect = 1'b1;
            npc      = mepc;
          end else if (issue_q.csr == PRIV_EBREAK) begin
            ebreak = 1'b1;
          end
        end
      end
      default: ;
    endcase
  end

  assign wb_data = (issue_q.opcode == OP_LOAD) ? lsu.rsp_rdata :
                   is_sys                      ? csr_rdata     : alu_res;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy        <= 1'b0;
      req_q       <= 1'b0;
      res_valid_q <= 1'b0;
      redirect_q  <= 1'b0;
      ebreak_q    <= 1'b0;
    end else begin
      if (res_valid_q && res_ready_i) begin
        res_valid_q <= 1'b0;
      end
      if (accept) begin
        busy <= 1'b1;
      end
      // request goes out the cycle after capture, held until the response
      if (busy && is_mem && !req_q && !lsu.rsp_valid) begin
        req_q <= 1'b1;
      end
      if (mem_done) begin
        req_q <= 1'b0;
      end
      if (exec_fire || mem_done) begin
        busy        <= 1'b0;
        res_valid_q <= 1'b1;
        redirect_q  <= redirect;
        ebreak_q    <= ebreak;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      issue_q <= issue_i;
    end
    if (exec_fire || mem_done) begin
      wdata_q <= wb_data;
      npc_q   <= npc;
    end
  end

  assign lsu.req_valid = req_q;
  assign lsu.req_write = issue_q.opcode == OP_STORE;
  assign lsu.req_addr  = jump_target;
  assign lsu.req_wdata = issue_q.src2;

  assign res_valid_o    = res_valid_q;
  assign res_rd_o       = issue_q.rd;
  assign res_rf_we_o    = issue_q.rf_we;
  assign res_wdata_o    = wdata_q;
  assign res_redirect_o = redirect_q;
  assign res_npc_o      = npc_q;
  assign res_ebreak_o   = ebreak_q;

endmodule

`default_nettype wire

/* hdl/exu_csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module exu_csr_file (
  input  wire                  clk,
  input  wire                  rst,
  input  wire [11:0]           raddr_i,
  output logic [`EXU_XLEN-1:0] rdata_o,
  input  wire                  we_i,
  input  wire [11:0]           waddr_i,
  input  wire [`EXU_XLEN-1:0]  wdata_i,
  input  wire                  trap_i,
  input  wire [`EXU_XLEN-1:0]  trap_pc_i,
  input  wire                  mret_i,
  output logic [`EXU_XLEN-1:0] mtvec_o,
  output logic [`EXU_XLEN-1:0] mepc_o
);

  import exu_csr_pkg::*;

  logic [`EXU_XLEN-1:0] mstatus;
  logic [`EXU_XLEN-1:0] mtvec;
  logic [`EXU_XLEN-1:0] mepc;
  logic [`EXU_XLEN-1:0] mcause;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec   <= `EXU_MTVEC_RESET;
      mepc    <= '0;
      mcause  <= '0;
    end else if (trap_i) begin
      mepc   <= trap_pc_i;
      mcause <= `EXU_XLEN'(CAUSE_ECALL_M);
    end else if (mret_i) begin
      mstatus[MSTATUS_MIE]  <= mstatus[MSTATUS_MPIE];
      mstatus[MSTATUS_MPIE] <= 1'b1;
    end else if (we_i) begin
      case (waddr_i)
        CSR_MSTATUS: mstatus <= wdata_i;
        CSR_MTVEC:   mtvec   <= wdata_i;
        CSR_MEPC:    mepc    <= wdata_i;
        CSR_MCAUSE:  mcause  <= wdata_i;
        default:     ;
      endcase
    end
  end

  // unimplemented csrs read as zero
  always_comb begin
    case (raddr_i)
      CSR_MSTATUS: rdata_o = mstatus;
      CSR_MTVEC:   rdata_o = mtvec;
      CSR_MEPC:    rdata_o = mepc;
      CSR_MCAUSE:  rdata_o = mcause;
      default:     rdata_o = '0;
    endcase
  end

  assign mtvec_o = mtvec;
  assign mepc_o  = mepc;

endmodule

`default_nettype wire

/* hdl/exu_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module exu_alu (
  input  wire [`EXU_XLEN-1:0]  src1_i,
  input  wire [`EXU_XLEN-1:0]  src2_i,
  input  wire exu_op_pkg::alu_op_e op_i,
  output logic [`EXU_XLEN-1:0] res_o
);

  import exu_op_pkg::*;

  logic [5:0] shamt;
  logic       lt;
  logic       ltu;
  logic       eq;

  assign shamt = src2_i[5:0];
  assign lt    = $signed(src1_i) < $signed(src2_i);
  assign ltu   = src1_i < src2_i;
  assign eq    = src1_i == src2_i;

  always_comb begin
    case (op_i)
      ALU_ADD:  res_o = src1_i + src2_i;
      ALU_SUB:  res_o = src1_i - src2_i;
      ALU_SLL:  res_o = src1_i << shamt;
      ALU_SLT:  res_o = {{(`EXU_XLEN-1){1'b0}}, lt};
      ALU_SLTU: res_o = {{(`EXU_XLEN-1){1'b0}}, ltu};
      ALU_XOR:  res_o = src1_i ^ src2_i;
      ALU_SRL:  res_o = src1_i >> shamt;
      ALU_SRA:  res_o = $unsigned($signed(src1_i) >>> shamt);
      ALU_OR:   res_o = src1_i | src2_i;
      ALU_AND:  res_o = src1_i & src2_i;
      // compare results feed the branch decision
      ALU_SLE:  res_o = {{(`EXU_XLEN-1){1'b0}}, lt | eq};
      ALU_SLEU: res_o = {{(`EXU_XLEN-1){1'b0}}, ltu | eq};
      default:  res_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/lsu_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

interface lsu_if;

  logic                 req_valid;
  logic                 req_write;
  logic [`EXU_XLEN-1:0] req_addr;
  logic [`EXU_XLEN-1:0] req_wdata;

  // rsp_valid pulses once per request, also for stores
  logic                 rsp_valid;
  logic [`EXU_XLEN-1:0] rsp_rdata;

  modport core (
    output req_valid, req_write, req_addr, req_wdata,
    input  rsp_valid, rsp_rdata
  );

  modport mem (
    input  req_valid, req_write, req_addr, req_wdata,
    output rsp_valid, rsp_rdata
  );

endinterface

`default_nettype wire

/* hdl/exu_op_pkg.sv */
`default_nettype none

`include "exu_config.svh"

package exu_op_pkg;

  typedef enum logic [2:0] {
    OP_ALU_REG,
    OP_ALU_IMM,
    OP_LOAD,
    OP_STORE,
    OP_BRANCH,
    OP_JAL,
    OP_JALR,
    OP_SYSTEM
  } opcode_e;

  // sle and sleu serve bge and bgeu with swapped operands
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_SLE,
    ALU_SLEU
  } alu_op_e;

  // csr holds the funct12 code when sys_func is priv
  typedef struct packed {
    opcode_e                opcode;
    alu_op_e                alu_op;
    exu_csr_pkg::sys_func_e sys_func;
    logic [11:0]            csr;
    logic [4:0]             rd;
    logic                   rf_we;
    logic [`EXU_XLEN-1:0]   src1;
    logic [`EXU_XLEN-1:0]   src2;
    logic [`EXU_XLEN-1:0]   base;
    logic [`EXU_XLEN-1:0]   imm;
    logic [`EXU_XLEN-1:0]   pc;
  } issue_t;

endpackage

`default_nettype wire

/* hdl/exu_csr_pkg.sv */
`default_nettype none

package exu_csr_pkg;

  // same values as funct3 of the system opcode
  typedef enum logic [2:0] {
    SYS_PRIV   = 3'd0,
    SYS_CSRRW  = 3'd1,
    SYS_CSRRS  = 3'd2,
    SYS_CSRRC  = 3'd3,
    SYS_CSRRWI = 3'd5,
    SYS_CSRRSI = 3'd6,
    SYS_CSRRCI = 3'd7
  } sys_func_e;

  // funct12 of the privileged instructions
  typedef enum logic [11:0] {
    PRIV_ECALL  = 12'h000,
    PRIV_EBREAK = 12'h001,
    PRIV_MRET   = 12'h302
  } priv_code_e;

  localparam logic [11:0] CSR_MSTATUS = 12'h300;
  localparam logic [11:0] CSR_MTVEC   = 12'h305;
  localparam logic [11:0] CSR_MEPC    = 12'h341;
  localparam logic [11:0] CSR_MCAUSE  = 12'h342;

  localparam int unsigned MSTATUS_MIE  = 3;
  localparam int unsigned MSTATUS_MPIE = 7;

  // environment call from M-mode
  localparam int unsigned CAUSE_ECALL_M = 11;

endpackage

`default_nettype wire

/* hdl/exu_config.svh */
`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

// data and address width
`define EXU_XLEN 64

// data memory depth in doublewords
`define EXU_DMEM_WORDS 256

// trap vector after reset
`define EXU_MTVEC_RESET 64'h0000_0000_8000_0000

`endif
